// ==== fetch_front.f ====
hdl/fetch_pkg.sv
hdl/tlb_pkg.sv
hdl/jtlb_lookup.sv
hdl/itlb_buffer.sv
hdl/pre_fetch_stage.sv
hdl/fetch_front_top.sv
bench/fetch_front_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch_front testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_front_tb -f fetch_front.f -o fetch_front_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fetch_front_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== bench/fetch_front_tb.sv ====
`timescale 1ns/100ps

module fetch_front_tb
    import fetch_pkg::*;
    import tlb_pkg::*;
();

    // twice the summed test lengths
    localparam int cycle_limit = 2 * (10 + 600 + 400 + 300 + 100 + 100);

    typedef struct packed {
        logic [19:0] pfn;
        logic        ex;
        exc_code_t   code;
        logic        refill;
    } xlate_t;

    logic        clk = 1'b0;
    logic        reset;
    br_bus_t     br_bus;
    redirect_t   redirect;
    logic        fs_allowin, icache_busy, is_icache_inst, tlb_we;
    logic [31:0] cache_inst_addr;
    tlb_idx_t    tlb_windex;
    tlb_entry_t  tlb_wdata;
    logic [7:0]  cur_asid;
    fetch_bus_t  fetch_bus;
    logic        fetch_valid, inst_valid;
    icache_req_t icache_req;

    // reference model state, moved on each rising edge
    logic [31:0] m_pc;
    logic [19:0] m_buf_vpn;
    logic [7:0]  m_buf_asid;
    logic        m_ps_valid, m_flush_pend, m_refetch_pend, m_buf_valid;
    logic        m_stall, m_accept, last_accept;
    tlb_entry_t  m_tlb [tlb_entries];
    integer      seed = 32'h8c8231dd;
    int          errors = 0, err_base = 0, tests = 0, failed_tests = 0, cycles = 0;

    fetch_front_top dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] predict_next_pc(logic [31:0] pc, br_bus_t br, redirect_t rd);
        if (rd.eret) return rd.epc;
        if (rd.flush) return rd.refill ? refill_ex_pc : (rd.refetch ? rd.m1_pc : general_ex_pc);
        if (br.taken) return br.target;
        return pc + 32'd4;
    endfunction

    // tlb faults only count once the buffer holds the page
    function automatic xlate_t translate(logic [31:0] pc, logic [7:0] asid, logic ready);
        xlate_t r;
        logic   found;
        page_t  pg;
        r = '{pfn: {3'b000, pc[28:12]}, ex: 1'b0, code: ex_none, refill: 1'b0};
        found = 1'b0;
        pg = '0;
        if (pc[31:30] != 2'b10) begin
            for (int i = 0; i < tlb_entries; i++) begin
                if (!found && m_tlb[i].vpn2 == pc[31:13] &&
                    (m_tlb[i].g || m_tlb[i].asid == asid)) begin
                    found = 1'b1;
                    pg = pc[12] ? m_tlb[i].odd : m_tlb[i].even;
                end
            end
            r.pfn = pg.pfn;
            if (ready && (!found || !pg.v))
                r = '{pfn: pg.pfn, ex: 1'b1, code: ex_tlbl, refill: !found};
        end
        if (pc[1:0] != 2'b00) r = '{pfn: r.pfn, ex: 1'b1, code: ex_adel, refill: r.refill};
        return r;
    endfunction

    function automatic tlb_entry_t make_entry(logic [18:0] vpn2, logic g, logic [7:0] asid,
                                              logic [19:0] even_pfn, logic even_v,
                                              logic [19:0] odd_pfn, logic odd_v);
        tlb_entry_t e;
        e.vpn2 = vpn2;
        e.g    = g;
        e.asid = asid;
        e.even = '{pfn: even_pfn, c: 3'd3, d: 1'b0, v: even_v};
        e.odd  = '{pfn: odd_pfn, c: 3'd3, d: 1'b0, v: odd_v};
        return e;
    endfunction

    task automatic report_mismatch(string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic check_fetch(fetch_bus_t got, fetch_bus_t exp);
        if (got !== exp) report_mismatch($sformatf(
            "fetch bus v%b bdd%b pc %h ex%b code %0d, expected v%b bdd%b pc %h ex%b code %0d",
            got.valid, got.bdd, got.pc, got.ex, got.exc_code,
            exp.valid, exp.bdd, exp.pc, exp.ex, exp.exc_code));
    endtask

    task automatic check_req(icache_req_t got, icache_req_t exp, logic tag_known);
        if (!tag_known) got.tag = exp.tag;  // tag is stale while the buffer refills
        if (got !== exp) report_mismatch($sformatf("icache req %h/%h/%h, expected %h/%h/%h",
            got.index, got.tag, got.offset, exp.index, exp.tag, exp.offset));
    endtask

    task automatic check_level(logic got, logic exp, string name);
        if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    task automatic eval_comb;
        m_stall  = (m_pc[31:30] != 2'b10) &&
                   !(m_buf_valid && m_buf_vpn == m_pc[31:12] && m_buf_asid == cur_asid);
        m_accept = redirect.flush || (m_ps_valid && fs_allowin && !icache_busy && !m_stall);
    endtask

    task automatic update_model;
        if (reset) begin
            m_pc = reset_pc;
            {m_ps_valid, m_flush_pend, m_refetch_pend, m_buf_valid, last_accept} = '0;
            foreach (m_tlb[i]) m_tlb[i] = '0;
        end else begin
            eval_comb();
            last_accept = m_accept;
            if (m_stall) begin
                m_buf_vpn  = m_pc[31:12];
                m_buf_asid = cur_asid;
            end
            if (tlb_we) m_buf_valid = 1'b0;  // any write empties the buffer
            else if (m_stall) m_buf_valid = 1'b1;
            if (tlb_we) m_tlb[tlb_windex] = tlb_wdata;
            if (m_accept) m_pc = predict_next_pc(m_pc, br_bus, redirect);
            if (redirect.flush) m_flush_pend = 1'b1;
            else if (!icache_busy) m_flush_pend = 1'b0;
            if (redirect.refetch) m_refetch_pend = 1'b1;
            else if (!icache_busy) m_refetch_pend = 1'b0;
            m_ps_valid = 1'b1;
        end
    endtask

    task automatic check_outputs;
        xlate_t      x;
        logic        ev;
        icache_req_t er;
        eval_comb();
        x = translate(m_pc, cur_asid, !m_stall);
        if (is_icache_inst) ev = 1'b0;
        else if (m_flush_pend && !icache_busy && !m_refetch_pend) ev = 1'b1;
        else if (x.ex || m_stall) ev = 1'b0;
        else ev = m_accept && !m_refetch_pend;
        er = '{index: is_icache_inst ? cache_inst_addr[11:4] : m_pc[11:4], tag: x.pfn,
               offset: m_pc[3:0]};
        check_fetch(fetch_bus, '{valid: ev, bdd: br_bus.taken, pc: m_pc, ex: x.ex,
                                 exc_code: x.code});
        check_req(icache_req, er, !m_stall);
        check_level(inst_valid, ev, "inst_valid");
        check_level(fetch_valid, m_ps_valid && !icache_busy && !m_stall, "fetch_valid");
        check_level(dut.u_pre_fetch.u_itlb.refill_fault, x.refill, "refill_fault");
    endtask

    // compare process, sampled just after each rising edge
    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
            update_model();
            #1;
            check_outputs();
        end
        $display("timeout: the run went past %0d cycles before the tests finished", cycles);
        $display("Test failures found");
        $finish;
    end

    // mode 1 adds branches and redirects, mode 2 random cache instruction addresses
    task automatic drive_random(int n, int mode);
        logic [31:0] r;
        logic [31:0] q;
        repeat (n) begin
            @(negedge clk);
            r = $random(seed);
            q = $random(seed);
            fs_allowin  = (r[1:0] != 2'b00);
            icache_busy = (r[3:2] == 2'b00);
            br_bus   = '0;
            redirect = '0;
            if (mode == 1) begin
                br_bus = '{taken: (r[6:4] == 3'b000), target: {3'b101, q[28:2], 2'b00}};
                if (r[10:7] == 4'b0000) begin
                    redirect = '{flush: r[11], refill: r[12], refetch: r[13], eret: r[14],
                                 epc: {3'b101, q[31:5], 2'b00}, m1_pc: {3'b101, q[26:0], 2'b00}};
                end
            end else if (mode == 2) begin
                cache_inst_addr = q;
            end
        end
    endtask

    task automatic jump_to(logic [31:0] target);
        logic done;
        done = 1'b0;
        @(negedge clk);
        br_bus = '{taken: 1'b1, target: target};
        fs_allowin  = 1'b1;
        icache_busy = 1'b0;
        while (!done) begin  // hold the branch until it is taken
            @(negedge clk);
            done = last_accept;
        end
        br_bus = '0;
    endtask

    task automatic write_tlb(tlb_idx_t idx, tlb_entry_t e);
        @(negedge clk);
        tlb_we     = 1'b1;
        tlb_windex = idx;
        tlb_wdata  = e;
        @(negedge clk);
        tlb_we = 1'b0;
    endtask

    task automatic end_test(string name);
        int n;
        n = errors - err_base;
        tests++;
        if (n != 0) failed_tests++;
        $display("test %0d %s: %s, %0d mismatches", tests, name, (n == 0) ? "ok" : "wrong", n);
        err_base = errors;
    endtask

    initial begin
        logic [31:0] pages [7];
        pages = '{32'h0040_0000, 32'h0040_1000, 32'h0040_2000, 32'h0040_3000,
                  32'h0040_4000, 32'h0040_0002, 32'hbfc0_0102};
        reset = 1'b1;
        br_bus = '0;
        redirect = '0;
        {fs_allowin, icache_busy, is_icache_inst, tlb_we} = '0;
        cache_inst_addr = '0;
        tlb_windex = '0;
        tlb_wdata = '0;
        cur_asid = 8'h05;
        repeat (5) begin
            @(negedge clk);
            if (inst_valid !== 1'b0) report_mismatch("inst_valid high during reset");
        end
        reset = 1'b0;
        repeat (5) @(negedge clk);
        if (fetch_bus.pc !== reset_pc)
            report_mismatch($sformatf("pc %h after reset", fetch_bus.pc));
        end_test("reset");
        drive_random(600, 0);
        end_test("sequential kseg1");
        drive_random(400, 1);
        end_test("branch and redirect");
        write_tlb(3'd0, make_entry(19'h00200, 1'b0, 8'h05, 20'h12345, 1'b1, 20'h0abcd, 1'b1));
        write_tlb(3'd1, make_entry(19'h00201, 1'b1, 8'h77, 20'h01111, 1'b0, 20'h05555, 1'b1));
        foreach (pages[i]) begin
            jump_to(pages[i]);
            drive_random(30, 0);
        end
        end_test("mapped fetch");
        jump_to(32'h0040_4000);  // unmapped page, refill fault
        drive_random(5, 0);
        write_tlb(3'd5, make_entry(19'h00202, 1'b1, 8'h00, 20'h0aaaa, 1'b1, 20'h0bbbb, 1'b1));
        write_tlb(3'd2, make_entry(19'h00202, 1'b0, 8'h05, 20'h0fedc, 1'b1, 20'h0cdef, 1'b1));
        fs_allowin  = 1'b1;
        icache_busy = 1'b0;
        while (!fetch_valid) @(negedge clk);
        if (icache_req.tag !== 20'h0fedc)
            report_mismatch($sformatf("tag %h after tlb write, expected 0fedc", icache_req.tag));
        drive_random(60, 0);
        end_test("tlb write flush");
        is_icache_inst = 1'b1;
        drive_random(100, 2);
        is_icache_inst = 1'b0;
        end_test("cache instruction");
        $display("%0d tests, %0d failed, %0d mismatches", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== hdl/fetch_front_top.sv ====
`timescale 1ns/100ps

module fetch_front_top
    import fetch_pkg::*;
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  br_bus_t     br_bus,
    input  redirect_t   redirect,
    input  logic        fs_allowin,
    input  logic        icache_busy,
    input  logic        is_icache_inst,
    input  logic [31:0] cache_inst_addr,
    input  logic        tlb_we,
    input  tlb_idx_t    tlb_windex,
    input  tlb_entry_t  tlb_wdata,
    input  logic [7:0]  cur_asid,
    output fetch_bus_t  fetch_bus,
    output logic        fetch_valid,
    output icache_req_t icache_req,
    output logic        inst_valid
);

    logic [18:0] lookup_vpn2;
    tlb_result_t jtlb_result;

    pre_fetch_stage u_pre_fetch (
        .clk             (clk),
        .reset           (reset),
        .fs_allowin      (fs_allowin),
        .br_bus          (br_bus),
        .redirect        (redirect),
        .icache_busy     (icache_busy),
        .is_icache_inst  (is_icache_inst),
        .cache_inst_addr (cache_inst_addr),
        .asid            (cur_asid),
        .tlb_flush       (tlb_we),          // any tlb write drops the buffered page
        .jtlb_result     (jtlb_result),
        .lookup_vpn2     (lookup_vpn2),
        .fetch_bus       (fetch_bus),
        .fetch_valid     (fetch_valid),
        .icache_req      (icache_req),
        .inst_valid      (inst_valid)
    );

    jtlb_lookup u_jtlb (
        .clk         (clk),
        .reset       (reset),
        .we          (tlb_we),
        .windex      (tlb_windex),
        .wdata       (tlb_wdata),
        .lookup_vpn2 (lookup_vpn2),
        .asid        (cur_asid),
        .result      (jtlb_result)
    );

endmodule

// ==== hdl/pre_fetch_stage.sv ====
`timescale 1ns/100ps

module pre_fetch_stage
    import fetch_pkg::*;
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        fs_allowin,
    input  br_bus_t     br_bus,
    input  redirect_t   redirect,
    input  logic        icache_busy,
    input  logic        is_icache_inst,
    input  logic [31:0] cache_inst_addr,
    input  logic [7:0]  asid,
    input  logic        tlb_flush,
    input  tlb_result_t jtlb_result,
    output logic [18:0] lookup_vpn2,
    output fetch_bus_t  fetch_bus,
    output logic        fetch_valid,
    output icache_req_t icache_req,
    output logic        inst_valid
);

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        ps_valid;       // low until the first cycle out of reset
    logic        ps_ready_go;
    logic        accept;
    logic        flush_pending;
    logic        refetch_pending;

    logic [19:0] pfn;
    logic        itlb_ex;
    exc_code_t   itlb_exc_code;
    logic        itlb_stall;
    logic        adel_ex;
    logic        ps_ex;
    exc_code_t   ps_exc_code;

    itlb_buffer u_itlb (
        .clk           (clk),
        .reset         (reset),
        .vpn           (pc[31:12]),
        .asid          (asid),
        .buffer_flush  (tlb_flush),
        .jtlb_result   (jtlb_result),
        .lookup_vpn2   (lookup_vpn2),
        .pfn           (pfn),
        .itlb_ex       (itlb_ex),
        .itlb_exc_code (itlb_exc_code),
        .itlb_stall    (itlb_stall),
        .refill_fault  ()
    );

    assign ps_ready_go = !icache_busy && !itlb_stall;
    assign accept      = redirect.flush || (ps_valid && fs_allowin && ps_ready_go);
    assign fetch_valid = ps_valid && ps_ready_go;

    always_comb begin
        if (redirect.eret) begin
            next_pc = redirect.epc;
        end else if (redirect.flush) begin
            if (redirect.refill) begin
                next_pc = refill_ex_pc;
            end else if (redirect.refetch) begin
                next_pc = redirect.m1_pc;  // restart the memory-stage instruction
            end else begin
                next_pc = general_ex_pc;
            end
        end else if (br_bus.taken) begin
            next_pc = br_bus.target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc              <= reset_pc;
            ps_valid        <= 1'b0;
            flush_pending   <= 1'b0;
            refetch_pending <= 1'b0;
        end else begin
            ps_valid <= 1'b1;
            if (accept) pc <= next_pc;
            // both pending flags wait for the cache to go idle
            if (redirect.flush) flush_pending <= 1'b1;
            else if (!icache_busy) flush_pending <= 1'b0;
            if (redirect.refetch) refetch_pending <= 1'b1;
            else if (!icache_busy) refetch_pending <= 1'b0;
        end
    end

    // address error wins over any tlb fault
    assign adel_ex     = (pc[1:0] != 2'b00);
    assign ps_ex       = adel_ex || itlb_ex;
    assign ps_exc_code = adel_ex ? ex_adel : (itlb_ex ? itlb_exc_code : ex_none);

    always_comb begin
        if (is_icache_inst) inst_valid = 1'b0;
        else if (flush_pending && !icache_busy && !refetch_pending) inst_valid = 1'b1;
        else if (ps_ex || itlb_stall) inst_valid = 1'b0;
        else inst_valid = accept && !refetch_pending;
    end

    assign fetch_bus = '{valid: inst_valid, bdd: br_bus.taken, pc: pc,
                         ex: ps_ex, exc_code: ps_exc_code};

    assign icache_req.index  = is_icache_inst ? cache_inst_addr[11:4] : pc[11:4];
    assign icache_req.tag    = pfn;
    assign icache_req.offset = pc[3:0];

    // the cache keeps the pc steady unless an exception redirects
    a_pc_hold_busy: assert property (
        @(posedge clk) disable iff (reset)
        (icache_busy && !redirect.flush) |=> $stable(pc)
    ) else $error("pc moved while icache busy");

endmodule

// ==== hdl/itlb_buffer.sv ====
`timescale 1ns/100ps

module itlb_buffer
    import fetch_pkg::*;
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [19:0] vpn,
    input  logic [7:0]  asid,
    input  logic        buffer_flush,
    input  tlb_result_t jtlb_result,
    output logic [18:0] lookup_vpn2,
    output logic [19:0] pfn,
    output logic        itlb_ex,
    output exc_code_t   itlb_exc_code,
    output logic        itlb_stall,
    output logic        refill_fault
);

    logic        buf_valid;
    logic [18:0] buf_vpn2;
    logic        buf_odd;   // which half of the pair is held
    logic [7:0]  buf_asid;
    logic        buf_found;
    page_t       buf_page;

    logic unmapped;
    logic buf_hit;

    assign unmapped    = (vpn[19:18] == 2'b10); // kseg0 and kseg1
    assign lookup_vpn2 = vpn[19:1];

    assign buf_hit = buf_valid && (buf_vpn2 == vpn[19:1]) && (buf_odd == vpn[0]) &&
                     (buf_asid == asid);

    assign itlb_stall = !unmapped && !buf_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (buffer_flush) begin
            buf_valid <= 1'b0;
        end else if (itlb_stall) begin
            buf_valid <= 1'b1;
        end
    end

    // key and page captured on the miss edge
    always_ff @(posedge clk) begin
        if (itlb_stall) begin
            buf_vpn2  <= vpn[19:1];
            buf_odd   <= vpn[0];
            buf_asid  <= asid;
            buf_found <= jtlb_result.found;
            buf_page  <= vpn[0] ? jtlb_result.odd : jtlb_result.even;
        end
    end

    assign pfn = unmapped ? {3'b000, vpn[16:0]} : buf_page.pfn;

    // faults only once the buffer holds this page
    assign refill_fault  = !unmapped && buf_hit && !buf_found;
    assign itlb_ex       = !unmapped && buf_hit && (!buf_found || !buf_page.v);
    assign itlb_exc_code = itlb_ex ? ex_tlbl : ex_none;

    // a refill is a single cycle unless the request itself moved
    a_single_stall: assert property (
        @(posedge clk) disable iff (reset)
        (itlb_stall && !buffer_flush) |=> (!itlb_stall || $changed(vpn) || $changed(asid))
    ) else $error("itlb stall held past one cycle for vpn %h", vpn);

endmodule

// ==== hdl/jtlb_lookup.sv ====
`timescale 1ns/100ps

module jtlb_lookup
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  tlb_idx_t    windex,
    input  tlb_entry_t  wdata,
    input  logic [18:0] lookup_vpn2,
    input  logic [7:0]  asid,
    output tlb_result_t result
);

    tlb_entry_t entries [tlb_entries];
    logic [tlb_entries-1:0] hit;

    // write port, entry visible from the next edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_entries; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[windex] <= wdata;
        end
    end

    // per-entry match on vpn2 plus global or asid
    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            hit[i] = (entries[i].vpn2 == lookup_vpn2) &&
                     (entries[i].g || (entries[i].asid == asid));
        end
    end

    // walk downwards so the lowest matching index is the last to land
    always_comb begin
        result = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (hit[i]) begin
                result.found = 1'b1;
                result.even  = entries[i].even;
                result.odd   = entries[i].odd;
            end
        end
    end

    // a write must name a driven entry
    a_windex_known: assert property (
        @(posedge clk) disable iff (reset)
        we |-> !$isunknown(windex)
    ) else $error("jtlb write with unknown index %b", windex);

endmodule

// ==== hdl/tlb_pkg.sv ====
package tlb_pkg;

    localparam int tlb_entries = 8;

    typedef logic [2:0] tlb_idx_t;

    // one half of a dual-page entry
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;   // cache attribute
        logic        d;   // dirty
        logic        v;   // valid
    } page_t;

    typedef struct packed {
        logic [18:0] vpn2;  // virtual page pair number
        logic        g;     // global, ignores asid
        logic [7:0]  asid;
        page_t       even;
        page_t       odd;
    } tlb_entry_t;

    // lookup result, both pages of the matching pair
    typedef struct packed {
        logic  found;
        page_t even;
        page_t odd;
    } tlb_result_t;

endpackage

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    localparam logic [31:0] reset_pc      = 32'hbfc0_0000; // boot rom entry
    localparam logic [31:0] general_ex_pc = 32'hbfc0_0380;
    localparam logic [31:0] refill_ex_pc  = 32'hbfc0_0200; // tlb refill vector, bev=1

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t ex_adel = 5'd4;  // address error on fetch
    localparam exc_code_t ex_tlbl = 5'd2;  // tlb refill or invalid on fetch
    localparam exc_code_t ex_none = 5'd31;

    // branch bus from decode
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // redirect from the memory stage
    typedef struct packed {
        logic        flush;   // exception being taken
        logic        refill;  // that exception is a tlb refill
        logic        refetch;
        logic        eret;
        logic [31:0] epc;
        logic [31:0] m1_pc;
    } redirect_t;

    typedef struct packed {
        logic        valid;
        logic        bdd;      // instruction after a branch delay slot
        logic [31:0] pc;
        logic        ex;
        exc_code_t   exc_code;
    } fetch_bus_t;

    typedef struct packed {
        logic [7:0]  index;
        logic [19:0] tag;
        logic [3:0]  offset;
    } icache_req_t;

endpackage
